// ==== eth_loop_pkg.sv ====
// shared widths, depths, frame sizes and led timing for the ethernet loopback channel
package eth_loop_pkg;

    // stream word format
    localparam int data_w = 64;
    localparam int keep_w = 8;              // one enable per byte

    // ethernet frame limits in 64-bit words
    localparam int min_frame_words = 8;     // 64 bytes
    localparam int max_frame_words = 32;    // 256 bytes, longer frames are marked bad

    // frame fifo storage
    localparam int fifo_depth = 64;
    localparam int fifo_addr_w = 6;

    // status counters shown on the leds
    localparam int cnt_w = 8;

    // led shift register
    localparam int led_count = 8;           // per color
    // system clocks per half period of sreg_clk, small so the testbench sees refreshes fast
    localparam int led_prescale = 3;

endpackage

// ==== axis_if.sv ====
// valid/ready frame stream carrying 64-bit words between the blocks of the channel
interface axis_if import eth_loop_pkg::*; ();

    logic [data_w-1:0] tdata;
    logic [keep_w-1:0] tkeep;
    logic              tlast;
    logic              tuser;   // bad frame, only meaningful with tlast
    logic              tvalid;
    logic              tready;

    // word producer
    modport source (
        output tdata,
        output tkeep,
        output tlast,
        output tuser,
        output tvalid,
        input  tready
    );

    // word consumer
    modport sink (
        input  tdata,
        input  tkeep,
        input  tlast,
        input  tuser,
        input  tvalid,
        output tready
    );

endinterface

// ==== rx_frame_check.sv ====
// receive register slice that counts words per frame and marks oversize frames bad
module rx_frame_check import eth_loop_pkg::*; (
    input  logic   clk_125mhz,
    input  logic   rst_n,
    axis_if.sink   s,
    axis_if.source m
);

    logic [$clog2(max_frame_words+1)-1:0] word_cnt;   // words of this frame so far
    logic live;        // set once out of reset
    logic oversize;    // current word lies past the size limit
    logic take;

    // count saturates at the limit, so every word from there on is oversize
    assign oversize = (word_cnt == max_frame_words);

    // accept when the slice is empty or draining this cycle
    assign s.tready = live && (!m.tvalid || m.tready);
    assign take = s.tvalid && s.tready;

    always_ff @(posedge clk_125mhz) begin
        if (!rst_n) begin
            live     <= 1'b0;
            m.tvalid <= 1'b0;
            word_cnt <= '0;
        end else begin
            live <= 1'b1;
            if (take) begin
                m.tvalid <= 1'b1;
                if (s.tlast) begin
                    word_cnt <= '0;                  // next word starts a frame
                end else if (!oversize) begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end else if (m.tready) begin
                m.tvalid <= 1'b0;
            end
        end
    end

    // word payload
    always_ff @(posedge clk_125mhz) begin
        if (take) begin
            m.tdata <= s.tdata;
            m.tkeep <= s.tkeep;
            m.tlast <= s.tlast;
            // upstream error and our own length mark both end up in tuser
            m.tuser <= s.tuser || (s.tlast && oversize);
        end
    end

endmodule

// ==== frame_fifo.sv ====
// frame fifo that commits whole frames, drops bad or overflowing ones and counts both
module frame_fifo import eth_loop_pkg::*; (
    input  logic             clk_125mhz,
    input  logic             rst_n,
    axis_if.sink             s,
    axis_if.source           m,
    output logic [cnt_w-1:0] good_count,
    output logic [cnt_w-1:0] drop_count
);

    // each entry holds last, keep and data
    logic [data_w+keep_w:0] mem [fifo_depth];

    // pointers carry one wrap bit above the address
    logic [fifo_addr_w:0] wr_ptr;       // next free entry
    logic [fifo_addr_w:0] commit_ptr;   // end of the last good frame
    logic [fifo_addr_w:0] commit_rd;    // commit pointer as seen by the read side
    logic [fifo_addr_w:0] rd_ptr;       // next entry to move to the output

    logic full;
    logic drop_frame;    // discarding the rest of an overflowed frame
    logic wr_en;
    logic rd_en;
    logic words_ready;

    // drop-when-full, the input never stalls
    assign s.tready = 1'b1;
    // only good frames are ever committed
    assign m.tuser = 1'b0;

    assign full = (wr_ptr[fifo_addr_w] != rd_ptr[fifo_addr_w]) &&
                  (wr_ptr[fifo_addr_w-1:0] == rd_ptr[fifo_addr_w-1:0]);

    assign wr_en = s.tvalid && !drop_frame && !full;

    assign words_ready = (rd_ptr != commit_rd);
    assign rd_en = words_ready && (!m.tvalid || m.tready);

    // storage
    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            mem[wr_ptr[fifo_addr_w-1:0]] <= {s.tlast, s.tkeep, s.tdata};
        end
    end

    // write side
    always_ff @(posedge clk_125mhz) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            commit_ptr <= '0;
            drop_frame <= 1'b0;
            good_count <= '0;
            drop_count <= '0;
        end else if (s.tvalid) begin
            if (drop_frame) begin
                // wait for the end of the broken frame
                if (s.tlast) begin
                    drop_frame <= 1'b0;
                    drop_count <= drop_count + 1'b1;
                end
            end else if (full) begin
                wr_ptr <= commit_ptr;                // forget the partial frame
                if (s.tlast) begin
                    drop_count <= drop_count + 1'b1;
                end else begin
                    drop_frame <= 1'b1;
                end
            end else if (s.tlast) begin
                if (s.tuser) begin
                    wr_ptr     <= commit_ptr;        // bad frame, roll back
                    drop_count <= drop_count + 1'b1;
                end else begin
                    wr_ptr     <= wr_ptr + 1'b1;
                    commit_ptr <= wr_ptr + 1'b1;
                    good_count <= good_count + 1'b1;
                end
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    // read side, one stage behind the commit pointer
    always_ff @(posedge clk_125mhz) begin
        if (!rst_n) begin
            commit_rd <= '0;
            rd_ptr    <= '0;
            m.tvalid  <= 1'b0;
        end else begin
            commit_rd <= commit_ptr;
            if (rd_en) begin
                rd_ptr   <= rd_ptr + 1'b1;
                m.tvalid <= 1'b1;
            end else if (m.tready) begin
                m.tvalid <= 1'b0;
            end
        end
    end

    // output word register
    always_ff @(posedge clk_125mhz) begin
        if (rd_en) begin
            {m.tlast, m.tkeep, m.tdata} <= mem[rd_ptr[fifo_addr_w-1:0]];
        end
    end

endmodule

// ==== tx_frame_pad.sv ====
// transmit stage that pads short frames to the 64 byte minimum under back-pressure
module tx_frame_pad import eth_loop_pkg::*; (
    input  logic              clk_125mhz,
    input  logic              rst_n,
    axis_if.sink              s,
    output logic [data_w-1:0] tx_tdata,
    output logic [keep_w-1:0] tx_tkeep,
    output logic              tx_tvalid,
    output logic              tx_tlast,
    input  logic              tx_tready
);

    logic [$clog2(min_frame_words)-1:0] word_idx;   // saturates at the last minimum word
    logic padding;       // generating zero words
    logic out_free;
    logic short_last;

    assign out_free = !tx_tvalid || tx_tready;
    assign s.tready = out_free && !padding;          // no input while padding

    // frame ends before reaching the minimum length
    assign short_last = s.tlast && (word_idx != min_frame_words - 1);

    always_ff @(posedge clk_125mhz) begin
        if (!rst_n) begin
            tx_tvalid <= 1'b0;
            padding   <= 1'b0;
            word_idx  <= '0;
        end else if (out_free) begin
            if (padding) begin
                tx_tdata  <= '0;
                tx_tkeep  <= '1;
                tx_tvalid <= 1'b1;
                if (word_idx == min_frame_words - 1) begin
                    tx_tlast <= 1'b1;                // eighth word closes the frame
                    padding  <= 1'b0;
                    word_idx <= '0;
                end else begin
                    tx_tlast <= 1'b0;
                    word_idx <= word_idx + 1'b1;
                end
            end else if (s.tvalid) begin
                tx_tdata  <= s.tdata;
                tx_tvalid <= 1'b1;
                if (short_last) begin
                    tx_tkeep <= '1;                  // whole word counts toward the frame
                    tx_tlast <= 1'b0;
                    padding  <= 1'b1;
                    word_idx <= word_idx + 1'b1;
                end else begin
                    tx_tkeep <= s.tkeep;
                    tx_tlast <= s.tlast;
                    if (s.tlast) begin
                        word_idx <= '0;
                    end else if (word_idx != min_frame_words - 1) begin
                        word_idx <= word_idx + 1'b1;
                    end
                end
            end else begin
                tx_tvalid <= 1'b0;
            end
        end
    end

endmodule

// ==== led_sreg.sv ====
// serial driver for 8 red and 8 green leds behind an external shift register
module led_sreg import eth_loop_pkg::*; (
    input  logic                 clk_125mhz,
    input  logic                 rst_n,
    input  logic [led_count-1:0] led_g,
    input  logic [led_count-1:0] led_r,
    output logic                 sreg_d,
    output logic                 sreg_ld,
    output logic                 sreg_clk
);

    logic [$clog2(led_prescale+1)-1:0] presc_cnt;
    logic [$clog2(2*led_count)-1:0]    bit_cnt;
    logic [2*led_count-1:0]            shreg;
    logic [2*led_count-1:0]            pattern;
    logic                              busy;       // a refresh is shifting out

    // red before green for each index, msb first, leds are active low
    always_comb begin
        for (int i = 0; i < led_count; i++) begin
            pattern[2*i+1] = ~led_r[i];
            pattern[2*i]   = ~led_g[i];
        end
    end

    assign sreg_d = shreg[2*led_count-1];

    always_ff @(posedge clk_125mhz) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            presc_cnt <= '0;
            bit_cnt   <= '0;
            sreg_clk  <= 1'b0;
            sreg_ld   <= 1'b0;
        end else if (!busy) begin
            // latch pulse ends here and the next refresh begins
            sreg_ld   <= 1'b0;
            shreg     <= pattern;
            busy      <= 1'b1;
            presc_cnt <= '0;
            bit_cnt   <= '0;
        end else if (presc_cnt == led_prescale - 1) begin
            presc_cnt <= '0;
            if (!sreg_clk) begin
                sreg_clk <= 1'b1;
            end else begin
                sreg_clk <= 1'b0;                    // data may move while clk is low
                if (bit_cnt == 2*led_count - 1) begin
                    sreg_ld <= 1'b1;
                    busy    <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    shreg   <= {shreg[2*led_count-2:0], 1'b0};
                end
            end
        end else begin
            presc_cnt <= presc_cnt + 1'b1;
        end
    end

endmodule

// ==== fpga_core.sv ====
// one ethernet channel: receive check, frame fifo, transmit padding and status leds
module fpga_core import eth_loop_pkg::*; (
    input  logic              clk_125mhz,
    input  logic              rst_n,

    // receive stream
    input  logic [data_w-1:0] rx_tdata,
    input  logic [keep_w-1:0] rx_tkeep,
    input  logic              rx_tvalid,
    input  logic              rx_tlast,
    input  logic              rx_tuser,
    output logic              rx_tready,

    // transmit stream
    output logic [data_w-1:0] tx_tdata,
    output logic [keep_w-1:0] tx_tkeep,
    output logic              tx_tvalid,
    output logic              tx_tlast,
    input  logic              tx_tready,

    // led shift register
    output logic              led_sreg_d,
    output logic              led_sreg_ld,
    output logic              led_sreg_clk
);

    logic [cnt_w-1:0] good_count;
    logic [cnt_w-1:0] drop_count;

    axis_if rx_if ();
    axis_if chk_to_fifo ();
    axis_if fifo_to_pad ();

    // top level rx ports onto the checker input
    assign rx_if.tdata  = rx_tdata;
    assign rx_if.tkeep  = rx_tkeep;
    assign rx_if.tvalid = rx_tvalid;
    assign rx_if.tlast  = rx_tlast;
    assign rx_if.tuser  = rx_tuser;
    assign rx_tready    = rx_if.tready;

    rx_frame_check rx_check_i (
        .clk_125mhz (clk_125mhz),
        .rst_n      (rst_n),
        .s          (rx_if.sink),
        .m          (chk_to_fifo.source)
    );

    frame_fifo fifo_i (
        .clk_125mhz (clk_125mhz),
        .rst_n      (rst_n),
        .s          (chk_to_fifo.sink),
        .m          (fifo_to_pad.source),
        .good_count (good_count),
        .drop_count (drop_count)
    );

    tx_frame_pad tx_pad_i (
        .clk_125mhz (clk_125mhz),
        .rst_n      (rst_n),
        .s          (fifo_to_pad.sink),
        .tx_tdata   (tx_tdata),
        .tx_tkeep   (tx_tkeep),
        .tx_tvalid  (tx_tvalid),
        .tx_tlast   (tx_tlast),
        .tx_tready  (tx_tready)
    );

    // good frames on green, drops on red
    led_sreg led_sreg_i (
        .clk_125mhz (clk_125mhz),
        .rst_n      (rst_n),
        .led_g      (good_count),
        .led_r      (drop_count),
        .sreg_d     (led_sreg_d),
        .sreg_ld    (led_sreg_ld),
        .sreg_clk   (led_sreg_clk)
    );

endmodule

// ==== tb_clk_gen.sv ====
// testbench clock source for the 125 MHz system clock
module tb_clk_gen (
    output logic clk_125mhz
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_125mhz = 1'b0;
        forever #4 clk_125mhz = ~clk_125mhz;   // 8 ns period
    end

endmodule

// ==== fpga_core_assert.sv ====
// protocol assertions on the tx and internal streams and on the led shift register
module fpga_core_assert import eth_loop_pkg::*; (
    input logic              clk_125mhz,
    input logic              rst_n,
    input logic              rx_tready,
    input logic [data_w-1:0] tx_tdata,
    input logic [keep_w-1:0] tx_tkeep,
    input logic              tx_tlast,
    input logic              tx_tvalid,
    input logic              tx_tready,
    input logic              chk_tvalid,
    input logic [data_w-1:0] pad_tdata,
    input logic [keep_w-1:0] pad_tkeep,
    input logic              pad_tlast,
    input logic              pad_tvalid,
    input logic              pad_tready,
    input logic              led_sreg_d,
    input logic              led_sreg_ld,
    input logic              led_sreg_clk
);
    timeunit 1ns;
    timeprecision 1ps;

    tx_hold: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
        tx_tvalid && !tx_tready |=> tx_tvalid && $stable({tx_tdata, tx_tkeep, tx_tlast}))
        else $error("tx word changed while stalled");

    // fifo output register feeding the pad stage
    pad_hold: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
        pad_tvalid && !pad_tready |=> pad_tvalid && $stable({pad_tdata, pad_tkeep, pad_tlast}))
        else $error("fifo output word changed while stalled");

    reset_idle: assert property (@(posedge clk_125mhz)
        !rst_n |=> !tx_tvalid && !pad_tvalid && !chk_tvalid && !rx_tready)
        else $error("tvalid or rx_tready high during reset");

    // the frame fifo never pushes back, so rx stays open once out of reset
    rx_open: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
        $past(rst_n) |-> rx_tready)
        else $error("rx_tready low after reset");

    ld_pulse: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
        led_sreg_ld |=> !led_sreg_ld)
        else $error("led_sreg_ld longer than one cycle");

    // data may only move while the shift clock is low
    d_stable: assert property (@(posedge clk_125mhz) disable iff (!rst_n)
        led_sreg_clk |=> !led_sreg_clk || $stable(led_sreg_d))
        else $error("led_sreg_d changed while led_sreg_clk high");

endmodule

bind fpga_core fpga_core_assert assert_i (
    .clk_125mhz   (clk_125mhz),
    .rst_n        (rst_n),
    .rx_tready    (rx_tready),
    .tx_tdata     (tx_tdata),
    .tx_tkeep     (tx_tkeep),
    .tx_tlast     (tx_tlast),
    .tx_tvalid    (tx_tvalid),
    .tx_tready    (tx_tready),
    .chk_tvalid   (chk_to_fifo.tvalid),
    .pad_tdata    (fifo_to_pad.tdata),
    .pad_tkeep    (fifo_to_pad.tkeep),
    .pad_tlast    (fifo_to_pad.tlast),
    .pad_tvalid   (fifo_to_pad.tvalid),
    .pad_tready   (fifo_to_pad.tready),
    .led_sreg_d   (led_sreg_d),
    .led_sreg_ld  (led_sreg_ld),
    .led_sreg_clk (led_sreg_clk)
);

// ==== tb_fpga_core.sv ====
// testbench for the ethernet channel, frames from the tests file checked on tx and on the leds
module tb_fpga_core import eth_loop_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic              clk_125mhz;
    logic              rst_n = 1'b0;
    logic [data_w-1:0] rx_tdata = '0;
    logic [keep_w-1:0] rx_tkeep = '0;
    logic              rx_tvalid = 1'b0;
    logic              rx_tlast = 1'b0;
    logic              rx_tuser = 1'b0;
    logic              rx_tready;
    logic [data_w-1:0] tx_tdata;
    logic [keep_w-1:0] tx_tkeep;
    logic              tx_tvalid;
    logic              tx_tlast;
    logic              tx_tready = 1'b0;
    logic              led_sreg_d;
    logic              led_sreg_ld;
    logic              led_sreg_clk;

    logic [31:0] recs [128];     // kind, tag, length or argument, last keep, flags
    logic [31:0] in_q [$];
    logic [31:0] exp_q [$];
    logic [7:0]  exp_good;
    logic [7:0]  exp_drop;
    int          total_words = 0;
    int          exp_words = 0;    // tx words the expected frames add up to
    int          tx_words = 0;     // words taken by the tx sink
    int          frames_seen = 0;
    bit          loaded = 1'b0;
    bit          hold_tx = 1'b0;   // stalls tx to overfill the fifo
    int unsigned rng_state = 12166;

    tb_clk_gen clk_gen_i (.clk_125mhz (clk_125mhz));

    fpga_core dut_i (.*);

    function automatic int unsigned lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state >> 16;
    endfunction

    // payload word built from frame tag and word index
    function automatic logic [data_w-1:0] word_data(logic [7:0] tag, logic [7:0] idx);
        return {tag, idx, 16'ha5c3, ~tag, ~idx, tag ^ idx, 8'h3c};
    endfunction

    task automatic fail_now(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // random back-pressure on tx
    always @(posedge clk_125mhz) begin
        tx_tready <= !hold_tx && (lcg_next() % 4 != 0);
    end

    // count every word the tx sink takes
    always @(posedge clk_125mhz) begin
        if (tx_tvalid && tx_tready) begin
            tx_words++;
        end
    end

    task automatic send_frame(logic [31:0] rec);
        int  len;
        int  gap;
        bit  accepted;
        len = rec[19:12];
        for (int i = 0; i < len; i++) begin
            gap = lcg_next() % 3;
            if (gap != 0) begin
                rx_tvalid <= 1'b0;
                repeat (gap) @(posedge clk_125mhz);
            end
            rx_tdata  <= word_data(rec[27:20], 8'(i));
            rx_tkeep  <= (i == len - 1) ? rec[11:4] : 8'hff;
            rx_tlast  <= (i == len - 1);
            rx_tuser  <= (i == len - 1) && rec[0];
            rx_tvalid <= 1'b1;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk_125mhz);
                accepted = rx_tready;
                @(posedge clk_125mhz);
            end
        end
    endtask

    task automatic drive_frames();
        foreach (in_q[n]) begin
            if (in_q[n][31:28] == 4'h1) begin
                send_frame(in_q[n]);
            end else if (in_q[n][31:28] == 4'h4) begin
                rx_tvalid <= 1'b0;
                wait (frames_seen >= in_q[n][19:12]);   // earlier frames fully out
                @(negedge clk_125mhz);
                hold_tx = 1'b1;
                repeat (2) @(posedge clk_125mhz);
            end else begin
                rx_tvalid <= 1'b0;
                repeat (in_q[n][19:12]) @(posedge clk_125mhz);
                @(negedge clk_125mhz);
                hold_tx = 1'b0;
                @(posedge clk_125mhz);
            end
        end
        rx_tvalid <= 1'b0;
    endtask

    task automatic check_frames();
        int                len;
        int                out_len;
        logic [data_w-1:0] exp_data;
        logic [keep_w-1:0] exp_keep;
        logic              exp_last;
        foreach (exp_q[f]) begin
            len = exp_q[f][19:12];
            out_len = (len < min_frame_words) ? min_frame_words : len;   // short frames grow
            for (int w = 0; w < out_len; w++) begin
                exp_data = (w < len) ? word_data(exp_q[f][27:20], 8'(w)) : '0;
                exp_last = (w == out_len - 1);
                exp_keep = (exp_last && len >= min_frame_words) ? exp_q[f][11:4] : '1;
                @(negedge clk_125mhz);
                while (!(tx_tvalid && tx_tready)) @(negedge clk_125mhz);
                assert (tx_tdata == exp_data) else fail_now($sformatf(
                    "error tx_tdata word %0d: got %h expected %h", w, tx_tdata, exp_data));
                assert (tx_tkeep == exp_keep) else fail_now($sformatf(
                    "error tx_tkeep word %0d: got %h expected %h", w, tx_tkeep, exp_keep));
                assert (tx_tlast == exp_last) else fail_now($sformatf(
                    "error tx_tlast word %0d: got %h expected %h", w, tx_tlast, exp_last));
            end
            frames_seen++;
        end
    endtask

    task automatic check_leds();
        logic [2*led_count-1:0] bits;
        logic [led_count-1:0]   green;
        logic [led_count-1:0]   red;
        logic                   prev_clk;
        int                     n;
        @(negedge clk_125mhz);
        while (!led_sreg_ld) @(negedge clk_125mhz);   // end of the refresh in flight
        bits = '0;
        n = 0;
        prev_clk = led_sreg_clk;
        @(negedge clk_125mhz);
        while (!led_sreg_ld) begin
            if (led_sreg_clk && !prev_clk) begin
                bits = {bits[2*led_count-2:0], led_sreg_d};
                n++;
            end
            prev_clk = led_sreg_clk;
            @(negedge clk_125mhz);
        end
        assert (n == 2 * led_count) else fail_now($sformatf(
            "led refresh shifted %0d bits instead of %0d", n, 2 * led_count));
        for (int i = 0; i < led_count; i++) begin
            red[i]   = ~bits[2*i+1];   // red leads green at every index
            green[i] = ~bits[2*i];
        end
        assert (green == exp_good) else fail_now($sformatf(
            "error led green: got %h expected %h", green, exp_good));
        assert (red == exp_drop) else fail_now($sformatf(
            "error led red: got %h expected %h", red, exp_drop));
    endtask

    initial begin
        wait (loaded);
        repeat (400 * total_words) @(posedge clk_125mhz);
        fail_now("run timed out before all frames and the led refresh were checked");
    end

    initial begin
        for (int i = 0; i < 128; i++) recs[i] = '0;
        $readmemh("eth_loop_tests.txt", recs);
        for (int i = 0; i < 128 && recs[i][31:28] != 4'h0; i++) begin
            if (recs[i][31:28] == 4'h2) begin
                exp_q.push_back(recs[i]);
                exp_words += (recs[i][19:12] < min_frame_words) ? min_frame_words
                                                                 : recs[i][19:12];
            end else if (recs[i][31:28] == 4'h3) begin
                exp_good = recs[i][27:20];
                exp_drop = recs[i][19:12];
            end else begin
                in_q.push_back(recs[i]);
                if (recs[i][31:28] == 4'h1) total_words += recs[i][19:12];
            end
        end
        assert (exp_q.size() > 0) else fail_now("tests file missing or holds no expected frames");
        loaded = 1'b1;
        repeat (5) @(posedge clk_125mhz);
        rst_n <= 1'b1;
        @(posedge clk_125mhz);
        fork
            drive_frames();
            check_frames();
        join
        check_leds();
        assert (!tx_tvalid) else fail_now("tx sent a word after the last expected frame");
        assert (tx_words == exp_words) else fail_now($sformatf(
            "tx carried %0d words in all instead of %0d", tx_words, exp_words));
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== eth_loop_tests.txt ====
// kind(1) tag(2) len(2) keep(2) flags(1) in hex; 1 rx frame, 2 expected tx frame, 3 counts
// 4 stall tx once len frames are out, 5 release after len cycles; flags bit0 sets rx_tuser
101080f0 // eight words, partial keep on last
201080f0
1020c3f0 // twelve words
2020c3f0
10301010 // single word, padded to eight
20301010
10507ff0 // seven words, one pad word
20507ff0
10609ff1 // bad from upstream, dropped
10721ff0 // 33 words, oversize
10808800 // eight words after the drops
20808800
40005000 // stall tx after five frames
1110aff0 // burst of ten word frames
1120a7f0
1130a3f0
1140a1f0
1150a0f0
1160a070
1170a030 // no room left, dropped
2110aff0
2120a7f0
2130a3f0
2140a1f0
2150a0f0
2160a070
5000a000 // let tx run again
12003030 // three words, padded
22003030
30c03000 // twelve good, three dropped
00000000

// ==== eth_loop.f ====
eth_loop_pkg.sv
axis_if.sv
rx_frame_check.sv
frame_fifo.sv
tx_frame_pad.sv
led_sreg.sv
fpga_core.sv
tb_clk_gen.sv
fpga_core_assert.sv
tb_fpga_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the channel testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_fpga_core -f eth_loop.f -o sim_eth_loop &&
./obj_dir/sim_eth_loop | tee /dev/stderr | grep -q "TEST PASSED" &&
echo "simulation ok" || { echo "simulation failed"; exit 1; }
